/* logic/tile_pkg.sv */
package tile_pkg;

  // Data path widths
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;

  // Word address into the data memory
  typedef logic [15:0] addr_t;

  // Word offset inside the broadcast region
  typedef logic [7:0]  msg_off_t;

  // Broadcast message {offset, strobe, data}
  typedef logic [43:0] bc_msg_t;

  // Current owner of the data memory
  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_BC,
    GRANT_DMA,
    GRANT_CORE
  } grant_t;

endpackage

/* logic/dmem_bank.sv */
`timescale 1ns/100ps

module dmem_bank
  import tile_pkg::*;
#(
  parameter int DMEM_WORDS = 1024
) (
  input  logic  clk,
  input  logic  mem_en,
  input  logic  mem_wen,
  input  strb_t mem_strb,
  input  addr_t mem_addr,
  input  word_t mem_wr_data,
  output word_t mem_rd_data
);

  localparam int ADDR_BITS = $clog2(DMEM_WORDS);

  word_t mem [DMEM_WORDS];

  // Only the low address bits select a word
  logic [ADDR_BITS-1:0] index;

  assign index = mem_addr[ADDR_BITS-1:0];

  always_ff @(posedge clk) begin
    if (mem_en && mem_wen) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_strb[b]) begin
          mem[index][8*b +: 8] <= mem_wr_data[8*b +: 8];
        end
      end
    end
    // Read word is ready one cycle later
    if (mem_en && !mem_wen) begin
      mem_rd_data <= mem[index];
    end
  end

endmodule

/* logic/dmem_arbiter.sv */
`timescale 1ns/100ps

module dmem_arbiter
  import tile_pkg::*;
#(
  parameter int DMEM_WORDS      = 1024,
  parameter int BC_REGION_WORDS = 64
) (
  input  logic    clk,
  input  logic    rst_n,

  input  bc_msg_t bc_msg_in,
  input  logic    bc_msg_in_valid,

  input  logic    dma_req,
  input  logic    dma_wen,
  input  strb_t   dma_strb,
  input  addr_t   dma_addr,
  input  word_t   dma_wr_data,
  output logic    dma_gnt,
  output logic    dma_rd_valid,

  input  logic    core_mem_en,
  input  logic    core_mem_wen,
  input  strb_t   core_mem_strb,
  input  addr_t   core_mem_addr,
  input  word_t   core_mem_wr_data,
  output logic    core_mem_ready,
  output logic    core_mem_rd_valid,

  input  logic    bc_block,

  output logic    mem_en,
  output logic    mem_wen,
  output strb_t   mem_strb,
  output addr_t   mem_addr,
  output word_t   mem_wr_data,

  output grant_t  grant
);

  localparam addr_t BC_BASE = addr_t'(DMEM_WORDS - BC_REGION_WORDS);

  msg_off_t bc_off;
  strb_t    bc_strb;
  word_t    bc_data;
  logic     core_ok;
  grant_t   rd_tag;

  assign {bc_off, bc_strb, bc_data} = bc_msg_in;

  // Core writes wait while a broadcast message is pending
  assign core_ok = core_mem_en && !(core_mem_wen && bc_block);

  ////////////////////////////////////////////////////////////////////////////
  // Fixed priority of broadcast-in over DMA over core
  always_comb begin
    if (bc_msg_in_valid) begin
      grant = GRANT_BC;
    end else if (dma_req) begin
      grant = GRANT_DMA;
    end else if (core_ok) begin
      grant = GRANT_CORE;
    end else begin
      grant = GRANT_NONE;
    end
  end

  assign dma_gnt        = (grant == GRANT_DMA);
  assign core_mem_ready = (grant == GRANT_CORE);

  always_comb begin
    mem_en      = 1'b1;
    mem_wen     = core_mem_wen;
    mem_strb    = core_mem_strb;
    mem_addr    = core_mem_addr;
    mem_wr_data = core_mem_wr_data;
    case (grant)
      GRANT_BC: begin
        mem_wen     = 1'b1;
        mem_strb    = bc_strb;
        mem_addr    = BC_BASE + addr_t'(bc_off);
        mem_wr_data = bc_data;
      end
      GRANT_DMA: begin
        mem_wen     = dma_wen;
        mem_strb    = dma_strb;
        mem_addr    = dma_addr;
        mem_wr_data = dma_wr_data;
      end
      GRANT_CORE: ;
      default: mem_en = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read tag records which requester gets the data next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_tag <= GRANT_NONE;
    end else if (mem_en && !mem_wen) begin
      rd_tag <= grant;
    end else begin
      rd_tag <= GRANT_NONE;
    end
  end

  assign dma_rd_valid      = (rd_tag == GRANT_DMA);
  assign core_mem_rd_valid = (rd_tag == GRANT_CORE);

endmodule

/* logic/dma_port.sv */
`timescale 1ns/100ps

module dma_port
  import tile_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  input  logic  dma_cmd_wr_en,
  input  addr_t dma_cmd_wr_addr,
  input  word_t dma_cmd_wr_data,
  input  strb_t dma_cmd_wr_strb,
  output logic  dma_cmd_wr_ready,

  input  logic  dma_cmd_rd_en,
  input  addr_t dma_cmd_rd_addr,
  output logic  dma_cmd_rd_ready,

  output logic  dma_rd_resp_valid,
  output word_t dma_rd_resp_data,
  input  logic  dma_rd_resp_ready,

  input  word_t mem_rd_data,

  output logic  dma_req,
  output logic  dma_wen,
  output strb_t dma_strb,
  output addr_t dma_addr,
  output word_t dma_wr_data,
  input  logic  dma_gnt,
  input  logic  dma_rd_valid
);

  logic  resp_held;
  word_t resp_data;
  logic  rd_busy;

  // One read in flight or waiting to be taken
  assign rd_busy = dma_rd_valid || resp_held;

  // Write goes ahead of read
  assign dma_req     = dma_cmd_wr_en || (dma_cmd_rd_en && !rd_busy);
  assign dma_wen     = dma_cmd_wr_en;
  assign dma_addr    = dma_cmd_wr_en ? dma_cmd_wr_addr : dma_cmd_rd_addr;
  assign dma_strb    = dma_cmd_wr_strb;
  assign dma_wr_data = dma_cmd_wr_data;

  assign dma_cmd_wr_ready = dma_gnt && dma_cmd_wr_en;
  assign dma_cmd_rd_ready = dma_gnt && !dma_cmd_wr_en;

  // Memory data shows directly in the first response cycle
  assign dma_rd_resp_valid = dma_rd_valid || resp_held;
  assign dma_rd_resp_data  = resp_held ? resp_data : mem_rd_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_held <= 1'b0;
    end else if (dma_rd_valid) begin
      resp_held <= !dma_rd_resp_ready;
    end else if (dma_rd_resp_ready) begin
      resp_held <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dma_rd_valid) begin
      resp_data <= mem_rd_data;
    end
  end

endmodule

/* logic/bc_msg_monitor.sv */
`timescale 1ns/100ps

module bc_msg_monitor
  import tile_pkg::*;
#(
  parameter int DMEM_WORDS      = 1024,
  parameter int BC_REGION_WORDS = 64
) (
  input  logic    clk,
  input  logic    rst_n,

  input  grant_t  grant,
  input  logic    mem_en,
  input  logic    mem_wen,
  input  strb_t   mem_strb,
  input  addr_t   mem_addr,
  input  word_t   mem_wr_data,

  output bc_msg_t bc_msg_out,
  output logic    bc_msg_out_valid,
  input  logic    bc_msg_out_ready,

  output logic    bc_block
);

  localparam addr_t BC_BASE = addr_t'(DMEM_WORDS - BC_REGION_WORDS);

  logic     capture;
  msg_off_t offset;
  addr_t    rel_addr;

  // Only core writes in the region become messages
  assign capture = mem_en && mem_wen && (grant == GRANT_CORE)
                && (mem_addr >= BC_BASE);

  assign rel_addr = mem_addr - BC_BASE;
  assign offset   = rel_addr[7:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bc_msg_out_valid <= 1'b0;
    end else if (capture) begin
      bc_msg_out_valid <= 1'b1;
    end else if (bc_msg_out_ready) begin
      bc_msg_out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      bc_msg_out <= {offset, mem_strb, mem_wr_data};
    end
  end

  // Pending message holds off further core writes
  assign bc_block = bc_msg_out_valid;

endmodule

/* logic/core_tile.sv */
`timescale 1ns/100ps

module core_tile
  import tile_pkg::*;
#(
  parameter int DMEM_WORDS      = 1024,
  parameter int BC_REGION_WORDS = 64
) (
  input  logic    clk,
  input  logic    rst_n,

  // Core data port
  input  logic    core_mem_en,
  input  logic    core_mem_wen,
  input  strb_t   core_mem_strb,
  input  addr_t   core_mem_addr,
  input  word_t   core_mem_wr_data,
  output logic    core_mem_ready,
  output word_t   core_mem_rd_data,
  output logic    core_mem_rd_valid,

  // DMA port
  input  logic    dma_cmd_wr_en,
  input  addr_t   dma_cmd_wr_addr,
  input  word_t   dma_cmd_wr_data,
  input  strb_t   dma_cmd_wr_strb,
  output logic    dma_cmd_wr_ready,

  input  logic    dma_cmd_rd_en,
  input  addr_t   dma_cmd_rd_addr,
  output logic    dma_cmd_rd_ready,

  output logic    dma_rd_resp_valid,
  output word_t   dma_rd_resp_data,
  input  logic    dma_rd_resp_ready,

  // Broadcast messages
  input  bc_msg_t bc_msg_in,
  input  logic    bc_msg_in_valid,
  output bc_msg_t bc_msg_out,
  output logic    bc_msg_out_valid,
  input  logic    bc_msg_out_ready
);

  logic   dma_req;
  logic   dma_wen;
  strb_t  dma_strb;
  addr_t  dma_addr;
  word_t  dma_wr_data;
  logic   dma_gnt;
  logic   dma_rd_valid;

  logic   mem_en;
  logic   mem_wen;
  strb_t  mem_strb;
  addr_t  mem_addr;
  word_t  mem_wr_data;
  word_t  mem_rd_data;

  grant_t grant;
  logic   bc_block;

  // Read data is shared by core and DMA
  assign core_mem_rd_data = mem_rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // DMA command front end
  dma_port dma_port_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .dma_cmd_wr_en    (dma_cmd_wr_en),
    .dma_cmd_wr_addr  (dma_cmd_wr_addr),
    .dma_cmd_wr_data  (dma_cmd_wr_data),
    .dma_cmd_wr_strb  (dma_cmd_wr_strb),
    .dma_cmd_wr_ready (dma_cmd_wr_ready),
    .dma_cmd_rd_en    (dma_cmd_rd_en),
    .dma_cmd_rd_addr  (dma_cmd_rd_addr),
    .dma_cmd_rd_ready (dma_cmd_rd_ready),
    .dma_rd_resp_valid(dma_rd_resp_valid),
    .dma_rd_resp_data (dma_rd_resp_data),
    .dma_rd_resp_ready(dma_rd_resp_ready),
    .mem_rd_data      (mem_rd_data),
    .dma_req          (dma_req),
    .dma_wen          (dma_wen),
    .dma_strb         (dma_strb),
    .dma_addr         (dma_addr),
    .dma_wr_data      (dma_wr_data),
    .dma_gnt          (dma_gnt),
    .dma_rd_valid     (dma_rd_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Arbiter and data memory
  dmem_arbiter #(
    .DMEM_WORDS     (DMEM_WORDS),
    .BC_REGION_WORDS(BC_REGION_WORDS)
  ) dmem_arbiter_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .bc_msg_in        (bc_msg_in),
    .bc_msg_in_valid  (bc_msg_in_valid),
    .dma_req          (dma_req),
    .dma_wen          (dma_wen),
    .dma_strb         (dma_strb),
    .dma_addr         (dma_addr),
    .dma_wr_data      (dma_wr_data),
    .dma_gnt          (dma_gnt),
    .dma_rd_valid     (dma_rd_valid),
    .core_mem_en      (core_mem_en),
    .core_mem_wen     (core_mem_wen),
    .core_mem_strb    (core_mem_strb),
    .core_mem_addr    (core_mem_addr),
    .core_mem_wr_data (core_mem_wr_data),
    .core_mem_ready   (core_mem_ready),
    .core_mem_rd_valid(core_mem_rd_valid),
    .bc_block         (bc_block),
    .mem_en           (mem_en),
    .mem_wen          (mem_wen),
    .mem_strb         (mem_strb),
    .mem_addr         (mem_addr),
    .mem_wr_data      (mem_wr_data),
    .grant            (grant)
  );

  dmem_bank #(
    .DMEM_WORDS(DMEM_WORDS)
  ) dmem_bank_inst (
    .clk        (clk),
    .mem_en     (mem_en),
    .mem_wen    (mem_wen),
    .mem_strb   (mem_strb),
    .mem_addr   (mem_addr),
    .mem_wr_data(mem_wr_data),
    .mem_rd_data(mem_rd_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Broadcast monitor on the memory bus
  bc_msg_monitor #(
    .DMEM_WORDS     (DMEM_WORDS),
    .BC_REGION_WORDS(BC_REGION_WORDS)
  ) bc_msg_monitor_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .grant           (grant),
    .mem_en          (mem_en),
    .mem_wen         (mem_wen),
    .mem_strb        (mem_strb),
    .mem_addr        (mem_addr),
    .mem_wr_data     (mem_wr_data),
    .bc_msg_out      (bc_msg_out),
    .bc_msg_out_valid(bc_msg_out_valid),
    .bc_msg_out_ready(bc_msg_out_ready),
    .bc_block        (bc_block)
  );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk
);

  // Free running clock that starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

endmodule

/* testbench/core_tile_tb.sv */
`timescale 1ns/100ps

module core_tile_tb
  import tile_pkg::*;
();

  localparam int    DMEM_WORDS      = 1024;
  localparam int    BC_REGION_WORDS = 64;
  localparam int    AW              = $clog2(DMEM_WORDS);
  localparam addr_t BC_BASE         = addr_t'(DMEM_WORDS - BC_REGION_WORDS);
  localparam int    RANDOM_OPS      = 40;
  localparam int    POOL_SIZE       = 16;

  typedef enum logic [1:0] {OP_CORE, OP_DMA, OP_BC, OP_BC_DMA} port_t;

  typedef struct packed {
    port_t      port;
    logic       wen;
    addr_t      addr;
    word_t      data;
    strb_t      strb;
    logic [7:0] hold;
  } op_t;

  logic    clk;
  logic    rst_n;
  logic    core_mem_en;
  logic    core_mem_wen;
  logic    core_mem_ready;
  logic    core_mem_rd_valid;
  strb_t   core_mem_strb;
  addr_t   core_mem_addr;
  word_t   core_mem_wr_data;
  word_t   core_mem_rd_data;
  logic    dma_cmd_wr_en;
  logic    dma_cmd_wr_ready;
  logic    dma_cmd_rd_en;
  logic    dma_cmd_rd_ready;
  addr_t   dma_cmd_wr_addr;
  addr_t   dma_cmd_rd_addr;
  word_t   dma_cmd_wr_data;
  word_t   dma_rd_resp_data;
  strb_t   dma_cmd_wr_strb;
  logic    dma_rd_resp_valid;
  logic    dma_rd_resp_ready;
  bc_msg_t bc_msg_in;
  bc_msg_t bc_msg_out;
  logic    bc_msg_in_valid;
  logic    bc_msg_out_valid;
  logic    bc_msg_out_ready;

  op_t     ops[$];
  word_t   ref_mem [DMEM_WORDS];
  bc_msg_t last_msg;
  int      errors;
  int      tests_run;
  int      tests_failed;
  int      hold_left;
  logic    expect_block;
  logic    table_ready;

  tb_clock #(.PERIOD_NS(4.0)) clock_gen (.clk(clk));

  core_tile #(
    .DMEM_WORDS     (DMEM_WORDS),
    .BC_REGION_WORDS(BC_REGION_WORDS)
  ) DUT (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  function automatic word_t apply_strobes(word_t old, word_t data, strb_t strb);
    word_t result;
    result = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = data[8*b +: 8];
      end
    end
    return result;
  endfunction

  // Message is {offset, strobe, data}
  function automatic bc_msg_t build_msg(addr_t addr, strb_t strb, word_t data);
    msg_off_t off;
    off = msg_off_t'(addr - BC_BASE);
    return {off, strb, data};
  endfunction

  // Eight plain words and eight region words
  function automatic addr_t pool_addr(int k);
    if (k < 8) begin
      return addr_t'(16'h0040 + k);
    end
    return BC_BASE + 16'h0020 + addr_t'(k - 8);
  endfunction

  function automatic void add_op(port_t port, logic wen, addr_t addr, word_t data,
                                 strb_t strb, int hold);
    op_t op;
    op.port = port;
    op.wen  = wen;
    op.addr = addr;
    op.data = data;
    op.strb = strb;
    op.hold = 8'(hold);
    ops.push_back(op);
  endfunction

  function automatic string op_name(op_t op);
    string who;
    case (op.port)
      OP_CORE: who = "core";
      OP_DMA:  who = "dma";
      OP_BC:   who = "bc_in";
      default: who = "bc_in+dma";
    endcase
    return $sformatf("%s %s %h", who, op.wen ? "write" : "read", op.addr);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks and reporting
  task automatic compare(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %0h expected %0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic report_error(string what);
    $display("ERROR %s at %0t", what, $time);
    errors++;
  endtask

  task automatic end_test(string name, int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    end
  endtask

  // Count down the held-low bc_msg_out_ready after each rising edge
  task automatic step_hold();
    if (hold_left > 0) begin
      hold_left--;
      if (hold_left == 0) begin
        bc_msg_out_ready <= 1'b1;
      end
    end
  endtask

  task automatic release_ready();
    while (hold_left > 0) begin
      @(posedge clk);
      step_hold();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Port drivers
  task automatic core_access(logic wen, addr_t addr, word_t data, strb_t strb, int hold);
    int      blocked;
    bc_msg_t exp_msg;
    blocked = 0;
    @(posedge clk);
    core_mem_en      <= 1'b1;
    core_mem_wen     <= wen;
    core_mem_addr    <= addr;
    core_mem_wr_data <= data;
    core_mem_strb    <= strb;
    if (hold > 0) begin
      bc_msg_out_ready <= 1'b0;
    end
    @(negedge clk);
    while (!core_mem_ready) begin
      blocked++;
      if (bc_msg_out_valid) begin
        compare("bc_msg_out", 64'(bc_msg_out), 64'(last_msg));
      end
      @(posedge clk);
      step_hold();
      @(negedge clk);
    end
    if (wen && bc_msg_out_valid) begin
      report_error("core write accepted while a broadcast message was pending");
    end
    if (wen && expect_block && blocked == 0) begin
      report_error("core write was not held off by the pending message");
    end
    expect_block = 1'b0;
    @(posedge clk);
    core_mem_en <= 1'b0;
    @(negedge clk);
    if (wen) begin
      ref_mem[addr[AW-1:0]] = apply_strobes(ref_mem[addr[AW-1:0]], data, strb);
      if (addr >= BC_BASE) begin
        exp_msg = build_msg(addr, strb, data);
        compare("bc_msg_out_valid", 64'(bc_msg_out_valid), 64'd1);
        compare("bc_msg_out", 64'(bc_msg_out), 64'(exp_msg));
        last_msg     = exp_msg;
        hold_left    = hold;
        expect_block = (hold > 0);
      end else begin
        compare("bc_msg_out_valid", 64'(bc_msg_out_valid), 64'd0);
      end
    end else begin
      compare("core_mem_rd_valid", 64'(core_mem_rd_valid), 64'd1);
      compare("core_mem_rd_data", 64'(core_mem_rd_data), 64'(ref_mem[addr[AW-1:0]]));
    end
  endtask

  task automatic dma_write(addr_t addr, word_t data, strb_t strb);
    @(posedge clk);
    dma_cmd_wr_en   <= 1'b1;
    dma_cmd_wr_addr <= addr;
    dma_cmd_wr_data <= data;
    dma_cmd_wr_strb <= strb;
    @(negedge clk);
    while (!dma_cmd_wr_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    dma_cmd_wr_en <= 1'b0;
    ref_mem[addr[AW-1:0]] = apply_strobes(ref_mem[addr[AW-1:0]], data, strb);
    @(negedge clk);
    compare("bc_msg_out_valid", 64'(bc_msg_out_valid), 64'd0);
  endtask

  // Response waits for hold cycles while a second read request stays pending
  // and a core read of the neighbor word moves the shared read data
  task automatic dma_read(addr_t addr, int hold);
    addr_t other;
    other = addr ^ 16'h0001;
    @(posedge clk);
    dma_cmd_rd_en   <= 1'b1;
    dma_cmd_rd_addr <= addr;
    @(negedge clk);
    while (!dma_cmd_rd_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    dma_cmd_rd_en     <= (hold > 0);
    dma_rd_resp_ready <= (hold == 0);
    if (hold > 0) begin
      core_mem_en   <= 1'b1;
      core_mem_wen  <= 1'b0;
      core_mem_addr <= other;
    end
    for (int i = 0; i <= hold; i++) begin
      @(negedge clk);
      compare("dma_rd_resp_valid", 64'(dma_rd_resp_valid), 64'd1);
      compare("dma_rd_resp_data", 64'(dma_rd_resp_data), 64'(ref_mem[addr[AW-1:0]]));
      compare("dma_cmd_rd_ready", 64'(dma_cmd_rd_ready), 64'd0);
      if (i == 1) begin
        compare("core_mem_rd_valid", 64'(core_mem_rd_valid), 64'd1);
        compare("core_mem_rd_data", 64'(core_mem_rd_data), 64'(ref_mem[other[AW-1:0]]));
      end
      @(posedge clk);
      core_mem_en <= 1'b0;
      if (i == hold - 1) begin
        dma_cmd_rd_en     <= 1'b0;
        dma_rd_resp_ready <= 1'b1;
      end else if (i == hold) begin
        dma_rd_resp_ready <= 1'b0;
      end
    end
    @(negedge clk);
    compare("dma_rd_resp_valid", 64'(dma_rd_resp_valid), 64'd0);
  endtask

  task automatic bc_write(addr_t addr, word_t data, strb_t strb);
    @(posedge clk);
    bc_msg_in       <= build_msg(addr, strb, data);
    bc_msg_in_valid <= 1'b1;
    @(posedge clk);
    bc_msg_in_valid <= 1'b0;
    ref_mem[addr[AW-1:0]] = apply_strobes(ref_mem[addr[AW-1:0]], data, strb);
    @(negedge clk);
    compare("bc_msg_out_valid", 64'(bc_msg_out_valid), 64'd0);
  endtask

  // Broadcast-in full word and DMA partial word to the same address
  task automatic bc_dma_collide(addr_t addr, word_t data, strb_t strb);
    @(posedge clk);
    bc_msg_in       <= build_msg(addr, 4'hf, ~data);
    bc_msg_in_valid <= 1'b1;
    dma_cmd_wr_en   <= 1'b1;
    dma_cmd_wr_addr <= addr;
    dma_cmd_wr_data <= data;
    dma_cmd_wr_strb <= strb;
    @(negedge clk);
    compare("dma_cmd_wr_ready", 64'(dma_cmd_wr_ready), 64'd0);
    @(posedge clk);
    bc_msg_in_valid <= 1'b0;
    ref_mem[addr[AW-1:0]] = ~data;
    @(negedge clk);
    while (!dma_cmd_wr_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    dma_cmd_wr_en <= 1'b0;
    ref_mem[addr[AW-1:0]] = apply_strobes(ref_mem[addr[AW-1:0]], data, strb);
    @(negedge clk);
    compare("bc_msg_out_valid", 64'(bc_msg_out_valid), 64'd0);
  endtask

  task automatic run_op(op_t op);
    case (op.port)
      OP_CORE: core_access(op.wen, op.addr, op.data, op.strb, int'(op.hold));
      OP_DMA: begin
        if (op.wen) begin
          dma_write(op.addr, op.data, op.strb);
        end else begin
          dma_read(op.addr, 2);
        end
      end
      OP_BC:   bc_write(op.addr, op.data, op.strb);
      default: bc_dma_collide(op.addr, op.data, op.strb);
    endcase
  endtask

  task automatic random_mix();
    addr_t addr;
    word_t data;
    strb_t strb;
    int    kind;
    // Fill the address pool first so every byte is known
    for (int k = 0; k < POOL_SIZE; k++) begin
      addr = pool_addr(k);
      dma_write(addr, {~addr, addr}, 4'hf);
    end
    for (int n = 0; n < RANDOM_OPS; n++) begin
      kind = int'($urandom % 4);
      addr = pool_addr(int'($urandom % POOL_SIZE));
      data = $urandom;
      strb = strb_t'($urandom);
      case (kind)
        0:       core_access(1'b0, addr, data, strb, 0);
        1:       core_access(1'b1, addr, data, strb, 0);
        2:       dma_read(addr, int'($urandom % 3));
        default: dma_write(addr, data, strb);
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  task automatic build_table();
    add_op(OP_DMA,  1'b1, 16'h0010, 32'h1122_3344, 4'hf, 0);
    add_op(OP_DMA,  1'b1, 16'h0010, 32'haabb_ccdd, 4'h5, 0);
    add_op(OP_DMA,  1'b1, 16'h0011, 32'h5566_7788, 4'hf, 0);
    add_op(OP_DMA,  1'b1, 16'h0011, 32'hdead_beef, 4'hc, 0);
    add_op(OP_CORE, 1'b0, 16'h0010, 32'h0, 4'h0, 0);
    add_op(OP_CORE, 1'b0, 16'h0011, 32'h0, 4'h0, 0);
    add_op(OP_DMA,  1'b0, 16'h0010, 32'h0, 4'h0, 0);
    add_op(OP_DMA,  1'b0, 16'h0011, 32'h0, 4'h0, 0);
    // Region write, plain write, read back
    add_op(OP_CORE, 1'b1, BC_BASE + 16'h5, 32'hcafe_f00d, 4'hf, 0);
    add_op(OP_CORE, 1'b1, 16'h0100, 32'h0102_0304, 4'hf, 0);
    add_op(OP_CORE, 1'b0, BC_BASE + 16'h5, 32'h0, 4'h0, 0);
    // Message held for 4 cycles blocks the next core write
    add_op(OP_CORE, 1'b1, BC_BASE + 16'h6, 32'h0bad_c0de, 4'hf, 4);
    add_op(OP_CORE, 1'b1, BC_BASE + 16'h6, 32'h1234_5678, 4'h6, 0);
    add_op(OP_CORE, 1'b0, BC_BASE + 16'h6, 32'h0, 4'h0, 0);
    // Broadcast-in alone and against a DMA write before the read back
    add_op(OP_BC,     1'b1, BC_BASE + 16'h2, 32'h7766_5544, 4'hf, 0);
    add_op(OP_BC_DMA, 1'b1, BC_BASE + 16'h3, 32'h9988_7766, 4'h3, 0);
    add_op(OP_DMA,    1'b0, BC_BASE + 16'h2, 32'h0, 4'h0, 0);
    add_op(OP_DMA,    1'b0, BC_BASE + 16'h3, 32'h0, 4'h0, 0);
    add_op(OP_CORE,   1'b0, 16'h0100, 32'h0, 4'h0, 0);
  endtask

  initial begin
    int  errors_before;
    op_t op;
    rst_n             <= 1'b0;
    core_mem_en       <= 1'b0;
    core_mem_wen      <= 1'b0;
    core_mem_strb     <= '0;
    core_mem_addr     <= '0;
    core_mem_wr_data  <= '0;
    dma_cmd_wr_en     <= 1'b0;
    dma_cmd_wr_addr   <= '0;
    dma_cmd_wr_data   <= '0;
    dma_cmd_wr_strb   <= '0;
    dma_cmd_rd_en     <= 1'b0;
    dma_cmd_rd_addr   <= '0;
    dma_rd_resp_ready <= 1'b0;
    bc_msg_in         <= '0;
    bc_msg_in_valid   <= 1'b0;
    bc_msg_out_ready  <= 1'b1;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    hold_left    = 0;
    expect_block = 1'b0;
    last_msg     = '0;
    void'($urandom(24));
    build_table();
    table_ready = 1'b1;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    errors_before = errors;
    @(negedge clk);
    compare("core_mem_ready", 64'(core_mem_ready), 64'd0);
    compare("core_mem_rd_valid", 64'(core_mem_rd_valid), 64'd0);
    compare("dma_cmd_wr_ready", 64'(dma_cmd_wr_ready), 64'd0);
    compare("dma_cmd_rd_ready", 64'(dma_cmd_rd_ready), 64'd0);
    compare("dma_rd_resp_valid", 64'(dma_rd_resp_valid), 64'd0);
    compare("bc_msg_out_valid", 64'(bc_msg_out_valid), 64'd0);
    end_test("outputs after reset", errors_before);

    foreach (ops[k]) begin
      op = ops[k];
      // Only a core write is meant to meet the held message
      if (hold_left > 0 && !(op.port == OP_CORE && op.wen)) begin
        release_ready();
      end
      errors_before = errors;
      run_op(op);
      end_test(op_name(op), errors_before);
    end
    release_ready();

    errors_before = errors;
    random_mix();
    end_test("random core and dma mix", errors_before);

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized from the table and the random block
  initial begin
    int limit;
    wait (table_ready === 1'b1);
    limit = 200 * (ops.size() + RANDOM_OPS);
    repeat (limit) @(posedge clk);
    $display("ERROR watchdog expired after %0d cycles", limit);
    $display("tests failed");
    $finish;
  end

endmodule

/* build.f */
logic/tile_pkg.sv
logic/dmem_bank.sv
logic/dmem_arbiter.sv
logic/dma_port.sv
logic/bc_msg_monitor.sv
logic/core_tile.sv
testbench/tb_clock.sv
testbench/core_tile_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps -f build.f \
  --top-module core_tile_tb -o core_tile_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/core_tile_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation did not run to completion"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
fi
exit 1
